//--- src/tag_track_pkg.sv
// Shared sizes and types for the request tag tracker
// N_TAGS must be a power of two and larger than 2 + MIN_FREE_SLOTS
`default_nettype none

package tag_track_pkg;

    // Heap geometry
    localparam int N_TAGS = 32;
    localparam int TAG_BITS = $clog2(N_TAGS);
    // No prefetch at or below this many free entries
    localparam int MIN_FREE_SLOTS = 1;
    // Two entries stay on the lists as permanent heads
    localparam int MAX_OUTSTANDING = N_TAGS - 2 - MIN_FREE_SLOTS;

    // Payload widths
    localparam int META_BITS = 24;
    localparam int DATA_BITS = 32;

    typedef logic [TAG_BITS-1:0] t_tag;
    typedef logic [DATA_BITS-1:0] t_data;

    // Request metadata, stored in the heap until the response
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] src_id;
        logic [META_BITS-9:0] addr;
    } t_meta;

    typedef struct packed {
        t_tag tag;
        t_data data;
    } t_rsp;

    typedef struct packed {
        t_meta meta;
        t_data data;
    } t_cmp;

endpackage

`default_nettype wire

//--- src/heap_ram.sv
// Simple dual-port RAM with N_TAGS words, no reset on contents
// Read data comes 1 + N_OUTPUT_REG_STAGES cycles after raddr
// Reading an address in its write cycle returns the old word
`default_nettype none

module heap_ram
    import tag_track_pkg::*;
#(
    parameter type t_word = t_tag,
    parameter int N_OUTPUT_REG_STAGES = 0
)
(
    input  wire logic clk,

    input  wire logic wen,
    input  wire t_tag waddr,
    input  wire t_word wdata,

    input  wire t_tag raddr,
    output t_word rdata
);

    // Storage array
    t_word mem [0:N_TAGS-1];

    // Registered read followed by the optional output stages
    t_word rd_pipe [0:N_OUTPUT_REG_STAGES];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        rd_pipe[0] <= mem[raddr];

        // Shift through the output stages, none when the count is 0
        for (int i = 0; i < N_OUTPUT_REG_STAGES; i++)
        begin
            rd_pipe[i+1] <= rd_pipe[i];
        end
    end

    assign rdata = rd_pipe[N_OUTPUT_REG_STAGES];

endmodule

`default_nettype wire

//--- src/alloc_fifo2.sv
// Two-entry FIFO of free indices ready for allocation
// Enqueue and dequeue may share a cycle; not_empty follows enqueue by one cycle
// Caller must not enqueue when full or dequeue when empty
`default_nettype none

module alloc_fifo2
    import tag_track_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic enq_en,
    input  wire t_tag enq_data,
    output logic not_full,

    output t_tag first,
    input  wire logic deq_en,
    output logic not_empty
);

    // Slot 0 is always the oldest entry
    t_tag data0;
    t_tag data1;
    logic valid0;
    logic valid1;

    assign first = data0;
    assign not_empty = valid0;
    assign not_full = !valid1;

    // Valid bits
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else if (deq_en)
        begin
            // Slot 1 moves up, or a new entry fills slot 0 directly
            valid0 <= valid1 || enq_en;
            valid1 <= 1'b0;
        end
        else
        begin
            valid0 <= valid0 || enq_en;
            valid1 <= valid1 || (enq_en && valid0);
        end
    end

    // Payload, no reset
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            data0 <= valid1 ? data1 : enq_data;
        end
        else if (enq_en && !valid0)
        begin
            data0 <= enq_data;
        end

        if (enq_en && valid0 && !deq_en)
        begin
            data1 <= enq_data;
        end
    end

    // Protocol checks on the caller
    a_no_enq_full: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> not_full)
        else $error("alloc_fifo2: enqueue while full");

    a_no_deq_empty: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("alloc_fifo2: dequeue while empty");

endmodule

`default_nettype wire

//--- src/tag_heap.sv
// Heap of N_TAGS metadata records with round-robin allocation
// Not ready for about N_TAGS cycles after reset while the free list fills
// Two entries stay reserved as list heads; a tag freed twice is not caught
// Record read data is valid the cycle after read_tag
`default_nettype none

module tag_heap
    import tag_track_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    // Allocation side
    input  wire logic alloc,
    input  wire t_meta alloc_meta,
    output logic not_full,
    output t_tag alloc_tag,

    // Lookup side
    input  wire t_tag read_tag,
    output t_meta read_meta,

    // Free side
    input  wire logic release_en,
    input  wire t_tag release_tag
);

    // ==============================
    // Record store
    // ==============================

    // Record written in the allocation cycle, no output stage
    heap_ram #(
        .t_word(t_meta),
        .N_OUTPUT_REG_STAGES(0)
    ) meta_ram (
        .clk,
        .wen(alloc),
        .waddr(alloc_tag),
        .wdata(alloc_meta),
        .raddr(read_tag),
        .rdata(read_meta)
    );

    // ==============================
    // Allocation prefetch
    // ==============================

    logic pop_free;
    logic need_pop;
    logic free_idx_avail;
    t_tag next_free_idx;

    // Pop whenever the prefetch FIFO has room and the list is deep enough
    assign pop_free = need_pop && free_idx_avail;

    alloc_fifo2 prefetch (
        .clk,
        .reset,
        .enq_en(pop_free),
        .enq_data(next_free_idx),
        .not_full(need_pop),
        .first(alloc_tag),
        .deq_en(alloc),
        .not_empty(not_full)
    );

    // ==============================
    // Free lists
    // ==============================

    // Two lists popped and pushed in turn hide the two-cycle link read
    t_tag free_head [0:1];
    t_tag free_head_q [0:1];
    t_tag free_tail [0:1];
    logic head_sel;
    logic tail_sel;

    logic initialized;
    t_tag init_idx;

    logic free_wen;
    t_tag free_wdata;
    t_tag free_rnext;

    assign next_free_idx = free_head[head_sel];

    // Link memory, entry i holds the successor of i
    heap_ram #(
        .t_word(t_tag),
        .N_OUTPUT_REG_STAGES(1)
    ) link_ram (
        .clk,
        .wen(free_wen),
        .waddr(free_tail[tail_sel]),
        .wdata(free_wdata),
        .raddr(free_head[head_sel]),
        .rdata(free_rnext)
    );

    // Pop tracking until the successor returns
    logic pop_q;
    logic pop_q2;
    logic head_sel_q;
    logic head_sel_q2;

    // Head of the list popped two cycles ago takes the link read data
    always_comb
    begin
        free_head[0] = free_head_q[0];
        free_head[1] = free_head_q[1];
        if (pop_q2)
        begin
            free_head[head_sel_q2] = free_rnext;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pop_q <= 1'b0;
            pop_q2 <= 1'b0;
            head_sel <= 1'b0;
            head_sel_q <= 1'b0;
            head_sel_q2 <= 1'b0;
            // Entries 0 and 1 start as the two heads
            free_head_q[0] <= t_tag'(0);
            free_head_q[1] <= t_tag'(1);
        end
        else
        begin
            pop_q <= pop_free;
            pop_q2 <= pop_q;
            head_sel_q <= head_sel;
            head_sel_q2 <= head_sel_q;
            free_head_q[0] <= free_head[0];
            free_head_q[1] <= free_head[1];
            if (pop_free)
            begin
                head_sel <= !head_sel;
            end
        end
    end

    // Released tag pushed one cycle later
    logic release_q;
    t_tag release_tag_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            release_q <= 1'b0;
        end
        else
        begin
            release_q <= release_en;
        end
        release_tag_q <= release_tag;
    end

    // Init walk shares the push port
    assign free_wen = !initialized || release_q;
    assign free_wdata = initialized ? release_tag_q : init_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_tail[0] <= t_tag'(0);
            free_tail[1] <= t_tag'(1);
            tail_sel <= 1'b0;
        end
        else if (free_wen)
        begin
            free_tail[tail_sel] <= free_wdata;
            tail_sel <= !tail_sel;
        end
    end

    // ==============================
    // Init walk and free count
    // ==============================

    t_tag num_free;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Walk starts after the two head entries
            init_idx <= t_tag'(2);
            initialized <= 1'b0;
            num_free <= '0;
            free_idx_avail <= 1'b0;
        end
        else if (!initialized)
        begin
            init_idx <= init_idx + t_tag'(1);
            if (init_idx == t_tag'(N_TAGS - 1))
            begin
                initialized <= 1'b1;
                // Heads are never counted, so neither list runs dry
                num_free <= t_tag'(N_TAGS - 2);
                free_idx_avail <= 1'b1;
            end
        end
        else if (release_q && !pop_free)
        begin
            num_free <= num_free + t_tag'(1);
            free_idx_avail <= (num_free + t_tag'(1)) > t_tag'(MIN_FREE_SLOTS);
        end
        else if (!release_q && pop_free)
        begin
            num_free <= num_free - t_tag'(1);
            free_idx_avail <= (num_free - t_tag'(1)) > t_tag'(MIN_FREE_SLOTS);
        end
    end

    // Requester must wait for ready
    a_alloc_ready: assert property (@(posedge clk) disable iff (reset)
        alloc |-> not_full)
        else $error("tag_heap: alloc while not ready");

    // A push beyond the count means a tag was freed twice
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (initialized && release_q && !pop_free) |-> (num_free < t_tag'(N_TAGS - 2)))
        else $error("tag_heap: free count overflow");

    // Popped list must still hold an entry behind its head
    a_no_empty_pop: assert property (@(posedge clk) disable iff (reset)
        pop_free |-> (free_head[head_sel] != free_tail[head_sel]))
        else $error("tag_heap: pop from empty free list");

endmodule

`default_nettype wire

//--- src/rsp_lookup.sv
// Response stage, one cycle from rsp_valid to cmp_valid and release
// Accepts a response every cycle; no back-pressure on completions
// Tag must name an outstanding request
`default_nettype none

module rsp_lookup
    import tag_track_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    // Incoming response
    input  wire logic rsp_valid,
    input  wire t_rsp rsp,

    // Heap read port, data returns next cycle
    output t_tag read_tag,
    input  wire t_meta read_meta,

    // Completion
    output logic cmp_valid,
    output t_cmp cmp,

    // Tag return to the free list
    output logic release_en,
    output t_tag release_tag
);

    logic rsp_valid_q;
    t_rsp rsp_q;

    // Address the heap straight from the incoming tag
    assign read_tag = rsp.tag;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= rsp_valid;
        end
        // Tag and data wait one cycle for the record
        rsp_q <= rsp;
    end

    // Join stored record with delayed data
    assign cmp_valid = rsp_valid_q;
    assign cmp.meta = read_meta;
    assign cmp.data = rsp_q.data;

    // Free in the same cycle as the completion
    assign release_en = rsp_valid_q;
    assign release_tag = rsp_q.tag;

endmodule

`default_nettype wire

//--- src/tag_track_top.sv
// Request tag tracker top level
// req_valid may only be raised while req_ready is high
// req_ready stays low during free-list init after reset
`default_nettype none

module tag_track_top
    import tag_track_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    // Requests
    input  wire logic req_valid,
    input  wire t_meta req_meta,
    output logic req_ready,
    output t_tag req_tag,

    // Responses, any order
    input  wire logic rsp_valid,
    input  wire t_rsp rsp,

    // Completions
    output logic cmp_valid,
    output t_cmp cmp
);

    // Lookup to heap
    t_tag read_tag;
    t_meta read_meta;
    logic release_en;
    t_tag release_tag;

    // Accept side, req_valid is the accept under the ready rule
    tag_heap heap (
        .clk,
        .reset,
        .alloc(req_valid),
        .alloc_meta(req_meta),
        .not_full(req_ready),
        .alloc_tag(req_tag),
        .read_tag,
        .read_meta,
        .release_en,
        .release_tag
    );

    // Lookup and release side
    rsp_lookup lookup (
        .clk,
        .reset,
        .rsp_valid,
        .rsp,
        .read_tag,
        .read_meta,
        .cmp_valid,
        .cmp,
        .release_en,
        .release_tag
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
// Clock and reset source for the tag tracker testbench
// 20 ns period; reset high for 16 rising edges, released 2 ns after the last
`default_nettype none

module tb_clock
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset released off the edge like any other input
    initial
    begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_tag_track.sv
// Testbench for tag_track_top, checks done by concurrent assertions
// Inputs change 2 ns after the rising edge; all waits are bounded loops
`default_nettype none

module tb_tag_track
    import tag_track_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int READY_TIMEOUT = 200;
    localparam int FILL_TIMEOUT = 400;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int RUN_CYCLES = 3000;

    logic clk;
    logic reset;
    logic req_valid;
    t_meta req_meta;
    logic req_ready;
    t_tag req_tag;
    logic rsp_valid;
    t_rsp rsp;
    logic cmp_valid;
    t_cmp cmp;

    int seed;
    int tag_errors = 0;
    int ready_errors = 0;
    int limit_errors = 0;
    int cmp_timing_errors = 0;
    int cmp_data_errors = 0;
    int timeout_errors = 0;
    int cover_errors = 0;

    // Reference model, indexed by tag
    logic [N_TAGS-1:0] outstanding;
    logic [N_TAGS-1:0] used;
    t_meta meta_ref [0:N_TAGS-1];
    logic exp_cmp_valid;
    t_cmp exp_cmp;

    tb_clock clock_gen (
        .clk,
        .reset
    );

    tag_track_top DUT (
        .clk,
        .reset,
        .req_valid,
        .req_meta,
        .req_ready,
        .req_tag,
        .rsp_valid,
        .rsp,
        .cmp_valid,
        .cmp
    );

    // ==============================
    // Reference model update
    // ==============================

    always @(posedge clk)
    begin
        exp_cmp_valid <= rsp_valid && !reset;
        if (reset)
        begin
            outstanding <= '0;
            used <= '0;
        end
        else
        begin
            // Expected completion captured with the response
            if (rsp_valid)
            begin
                exp_cmp.meta <= meta_ref[rsp.tag];
                exp_cmp.data <= rsp.data;
                outstanding[rsp.tag] <= 1'b0;
            end
            if (req_valid && req_ready)
            begin
                outstanding[req_tag] <= 1'b1;
                used[req_tag] <= 1'b1;
                meta_ref[req_tag] <= req_meta;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Outputs quiet on the first cycle out of reset
    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!req_ready && !cmp_valid))
        else
        begin
            ready_errors++;
            $display("[ERROR] req_ready cmp_valid: expected 0x0 0x0, got 0x%h 0x%h",
                $sampled(req_ready), $sampled(cmp_valid));
        end

    a_tag_free: assert property (@(posedge clk) disable iff (reset)
        (req_valid && req_ready) |-> !outstanding[req_tag])
        else
        begin
            tag_errors++;
            $display("[ERROR] req_tag: expected a free tag, got 0x%h", $sampled(req_tag));
        end

    // Ready must drop once every usable tag is held
    a_ready_limit: assert property (@(posedge clk) disable iff (reset)
        ($countones(outstanding) == MAX_OUTSTANDING) |-> !req_ready)
        else
        begin
            limit_errors++;
            $display("[ERROR] req_ready: expected 0x0, got 0x%h", $sampled(req_ready));
        end

    a_cmp_timing: assert property (@(posedge clk) disable iff (reset)
        cmp_valid == exp_cmp_valid)
        else
        begin
            cmp_timing_errors++;
            $display("[ERROR] cmp_valid: expected 0x%h, got 0x%h",
                $sampled(exp_cmp_valid), $sampled(cmp_valid));
        end

    a_cmp_data: assert property (@(posedge clk) disable iff (reset)
        (cmp_valid && exp_cmp_valid) |-> (cmp == exp_cmp))
        else
        begin
            cmp_data_errors++;
            $display("[ERROR] cmp: expected 0x%h, got 0x%h", $sampled(exp_cmp), $sampled(cmp));
        end

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Request driven only while ready, as the DUT requires
    task automatic drive_request(input logic want);
        logic [31:0] r;
        r = $random(seed);
        req_valid = want && req_ready;
        req_meta = r[META_BITS-1:0];
    endtask

    // Response for a random outstanding tag, if one exists
    task automatic drive_response(input logic want);
        logic [31:0] r;
        logic [31:0] d;
        t_tag start;
        t_tag tag;
        logic found;
        int i;
        r = $random(seed);
        d = $random(seed);
        start = r[TAG_BITS-1:0];
        found = 1'b0;
        for (i = 0; i < N_TAGS; i++)
        begin
            tag = start + t_tag'(i);
            if (!found && outstanding[tag])
            begin
                found = 1'b1;
                rsp.tag = tag;
            end
        end
        rsp.data = d;
        rsp_valid = want && found;
    endtask

    // Unknown values before the first edge count as not ready
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while ((reset !== 1'b0 || req_ready !== 1'b1) && cycles < READY_TIMEOUT)
        begin
            next_cycle();
            cycles++;
        end
        if (reset !== 1'b0 || req_ready !== 1'b1)
        begin
            timeout_errors++;
            $display("Timeout: req_ready never rose after reset");
        end
    endtask

    // Take tags until the DUT has handed out all it can
    task automatic fill_tags();
        int cycles;
        cycles = 0;
        while ($countones(outstanding) < MAX_OUTSTANDING && cycles < FILL_TIMEOUT)
        begin
            drive_request(1'b1);
            next_cycle();
            cycles++;
        end
        req_valid = 1'b0;
        if ($countones(outstanding) < MAX_OUTSTANDING)
        begin
            timeout_errors++;
            $display("Timeout: fewer tags handed out than the outstanding limit");
        end
    endtask

    task automatic drain_tags();
        int cycles;
        cycles = 0;
        req_valid = 1'b0;
        while (outstanding != '0 && cycles < DRAIN_TIMEOUT)
        begin
            drive_response(1'b1);
            next_cycle();
            cycles++;
        end
        rsp_valid = 1'b0;
        if (outstanding != '0)
        begin
            timeout_errors++;
            $display("Timeout: outstanding tags left after draining");
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        logic [31:0] r;
        int total;
        seed = 32'h89e8_9f0b;
        req_valid = 1'b0;
        req_meta = '0;
        rsp_valid = 1'b0;
        rsp = '0;

        wait_ready();

        // Fill with no responses, then hold while ready must stay low
        fill_tags();
        repeat (64) next_cycle();
        drain_tags();

        // Mixed traffic, requests favoured so the limit is hit often
        repeat (RUN_CYCLES)
        begin
            r = $random(seed);
            drive_request(r[1:0] != 2'b00);
            drive_response(r[2]);
            next_cycle();
        end
        drain_tags();
        repeat (4) next_cycle();

        // Round robin should have cycled through the heap
        a_all_tags_used: assert ($countones(used) >= N_TAGS - 2)
        else
        begin
            cover_errors++;
            $display("[ERROR] used tags: expected at least 0x%h, got 0x%h",
                N_TAGS - 2, $countones(used));
        end

        total = tag_errors + ready_errors + limit_errors + cmp_timing_errors
            + cmp_data_errors + timeout_errors + cover_errors;
        $display("Errors: tag %0d, reset %0d, limit %0d, cmp_valid %0d, cmp %0d, timeout %0d, used %0d",
            tag_errors, ready_errors, limit_errors, cmp_timing_errors,
            cmp_data_errors, timeout_errors, cover_errors);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
src/tag_track_pkg.sv
src/heap_ram.sv
src/alloc_fifo2.sv
src/tag_heap.sv
src/rsp_lookup.sv
src/tag_track_top.sv
verif/tb_clock.sv
verif/tb_tag_track.sv

//--- Makefile
SRCS := $(shell grep '\.sv$$' compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_tag_track: compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module tb_tag_track -o Vtb_tag_track

run: obj_dir/Vtb_tag_track
	./obj_dir/Vtb_tag_track > sim.log 2>&1 || (cat sim.log && false)
	cat sim.log
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log
